//--- src/uncore_pkg.sv
package uncore_pkg;

  localparam int PADDR_W  = 40;
  localparam int DATA_W   = 64;
  localparam int LCE_ID_W = 2;
  localparam int NUM_REQ  = 3;
  localparam int DOMAIN_W = 7;

  // Everything below the DRAM base is the local device space
  localparam logic [PADDR_W-1:0] DRAM_BASE = 40'h00_8000_0000;

  // Device slot held in address bits 23:20
  localparam logic [3:0] BOOT_DEV  = 4'd0;
  localparam logic [3:0] CLINT_DEV = 4'd1;
  localparam logic [3:0] CFG_DEV   = 4'd2;
  localparam logic [3:0] HOST_DEV  = 4'd3;
  localparam logic [3:0] CACHE_DEV = 4'd4;

  localparam logic [19:0] MSIP_OFF     = 20'h0_0000;
  localparam logic [19:0] MTIMECMP_OFF = 20'h0_4000;
  localparam logic [19:0] MTIME_OFF    = 20'h0_bff8;

  typedef union packed {
    logic [PADDR_W-1:0] raw;
    struct packed {
      logic [DOMAIN_W-1:0] domain;
      logic [8:0]          upper;
      logic [3:0]          dev;
      logic [19:0]         offset;
    } fields;
  } paddr_u;

endpackage

//--- src/mem_msg_if.sv
// One message channel, valid/ready handshake
interface mem_msg_if;

  logic                             v;
  logic                             ready;
  logic                             wr;
  logic [uncore_pkg::LCE_ID_W-1:0]  lce_id;
  uncore_pkg::paddr_u               addr;
  logic [uncore_pkg::DATA_W-1:0]    data;

  modport src
    (output v
    , output wr
    , output lce_id
    , output addr
    , output data
    , input  ready
    );

  modport dst
    (input  v
    , input  wr
    , input  lce_id
    , input  addr
    , input  data
    , output ready
    );

endinterface

//--- src/two_entry_fifo.sv
module two_entry_fifo
  (input  logic     clk_i
  , input logic     rst_n_i
  , mem_msg_if.dst  in_i
  , mem_msg_if.src  out_o
  );

  logic [1:0] full_q;
  logic       wptr_q;
  logic       rptr_q;
  logic       push;
  logic       pop;

  logic [1:0]                                 wr_q;
  logic [1:0][uncore_pkg::LCE_ID_W-1:0]       id_q;
  uncore_pkg::paddr_u [1:0]                   addr_q;
  logic [1:0][uncore_pkg::DATA_W-1:0]         data_q;

  assign in_i.ready = ~(&full_q);
  assign push       = in_i.v & in_i.ready;
  assign out_o.v    = full_q[rptr_q];
  assign pop        = out_o.v & out_o.ready;

  assign out_o.wr     = wr_q[rptr_q];
  assign out_o.lce_id = id_q[rptr_q];
  assign out_o.addr   = addr_q[rptr_q];
  assign out_o.data   = data_q[rptr_q];

  // Push and pop never hit the same slot
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      full_q <= 2'b00;
      wptr_q <= 1'b0;
      rptr_q <= 1'b0;
    end
    else
    begin
      if (push)
      begin
        full_q[wptr_q] <= 1'b1;
        wptr_q         <= ~wptr_q;
      end
      if (pop)
      begin
        full_q[rptr_q] <= 1'b0;
        rptr_q         <= ~rptr_q;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      wr_q[wptr_q]   <= in_i.wr;
      id_q[wptr_q]   <= in_i.lce_id;
      addr_q[wptr_q] <= in_i.addr;
      data_q[wptr_q] <= in_i.data;
    end
  end

endmodule

//--- src/cmd_router.sv
module cmd_router
  (mem_msg_if.dst  cmd_i [uncore_pkg::NUM_REQ]
  , mem_msg_if.src io_o
  , mem_msg_if.src mem_o
  , mem_msg_if.src local_o
  );

  logic [uncore_pkg::NUM_REQ-1:0]                             req;
  logic [uncore_pkg::NUM_REQ-1:0]                             grant;
  logic [uncore_pkg::NUM_REQ-1:0]                             wr_a;
  logic [uncore_pkg::NUM_REQ-1:0][uncore_pkg::LCE_ID_W-1:0]   id_a;
  logic [uncore_pkg::NUM_REQ-1:0][uncore_pkg::PADDR_W-1:0]    addr_a;
  logic [uncore_pkg::NUM_REQ-1:0][uncore_pkg::DATA_W-1:0]     data_a;

  logic                             all_ready;
  logic                             sel_wr;
  logic [uncore_pkg::LCE_ID_W-1:0]  sel_id;
  uncore_pkg::paddr_u               sel_addr;
  logic [uncore_pkg::DATA_W-1:0]    sel_data;
  logic                             is_local;
  logic                             is_io;
  logic                             is_mem;

  for (genvar i = 0; i < uncore_pkg::NUM_REQ; i++)
  begin : g_port
    assign req[i]         = cmd_i[i].v;
    assign wr_a[i]        = cmd_i[i].wr;
    assign id_a[i]        = cmd_i[i].lce_id;
    assign addr_a[i]      = cmd_i[i].addr.raw;
    assign data_a[i]      = cmd_i[i].data;
    assign cmd_i[i].ready = grant[i];
  end

  // A stalled destination blocks every port
  assign all_ready = io_o.ready & mem_o.ready & local_o.ready;

  // Higher index wins
  always_comb
  begin
    grant = '0;
    for (int i = 0; i < uncore_pkg::NUM_REQ; i++)
    begin
      if (req[i] && all_ready)
      begin
        grant    = '0;
        grant[i] = 1'b1;
      end
    end
  end

  always_comb
  begin
    sel_wr       = 1'b0;
    sel_id       = '0;
    sel_addr.raw = '0;
    sel_data     = '0;
    for (int i = 0; i < uncore_pkg::NUM_REQ; i++)
    begin
      sel_wr       = sel_wr | (wr_a[i] & grant[i]);
      sel_id       = sel_id | (id_a[i] & {uncore_pkg::LCE_ID_W{grant[i]}});
      sel_addr.raw = sel_addr.raw | (addr_a[i] & {uncore_pkg::PADDR_W{grant[i]}});
      sel_data     = sel_data | (data_a[i] & {uncore_pkg::DATA_W{grant[i]}});
    end
  end

  // Memory map decode
  assign is_local = sel_addr.raw < uncore_pkg::DRAM_BASE;
  assign is_io    = (sel_addr.fields.domain != '0)
                  | (is_local & ((sel_addr.fields.dev == uncore_pkg::BOOT_DEV)
                               | (sel_addr.fields.dev == uncore_pkg::HOST_DEV)));
  assign is_mem   = ~is_io & (~is_local | (sel_addr.fields.dev == uncore_pkg::CACHE_DEV));

  assign io_o.v    = (|grant) & is_io;
  assign mem_o.v   = (|grant) & is_mem;
  assign local_o.v = (|grant) & ~is_io & ~is_mem;

  assign io_o.wr        = sel_wr;
  assign io_o.lce_id    = sel_id;
  assign io_o.addr      = sel_addr;
  assign io_o.data      = sel_data;
  assign mem_o.wr       = sel_wr;
  assign mem_o.lce_id   = sel_id;
  assign mem_o.addr     = sel_addr;
  assign mem_o.data     = sel_data;
  assign local_o.wr     = sel_wr;
  assign local_o.lce_id = sel_id;
  assign local_o.addr   = sel_addr;
  assign local_o.data   = sel_data;

endmodule

//--- src/local_devices.sv
module local_devices
  (input  logic     clk_i
  , input logic     rst_n_i
  , mem_msg_if.dst  cmd_i
  , mem_msg_if.src  clint_resp_o
  , mem_msg_if.src  loop_resp_o
  , output logic    timer_irq_o
  , output logic    software_irq_o
  );

  logic [uncore_pkg::DATA_W-1:0]    mtime_q;
  logic [uncore_pkg::DATA_W-1:0]    mtimecmp_q;
  logic                             msip_q;
  logic                             timer_irq_q;

  logic                             clint_v_q;
  logic                             loop_v_q;
  logic                             resp_wr_q;
  logic [uncore_pkg::LCE_ID_W-1:0]  resp_id_q;
  uncore_pkg::paddr_u               resp_addr_q;
  logic [uncore_pkg::DATA_W-1:0]    clint_data_q;

  logic                             is_clint;
  logic                             accept;
  logic                             clint_wr;
  logic [uncore_pkg::DATA_W-1:0]    clint_rd;

  assign is_clint = cmd_i.addr.fields.dev == uncore_pkg::CLINT_DEV;

  // Either held response blocks new commands
  assign cmd_i.ready = ~clint_v_q & ~loop_v_q;
  assign accept      = cmd_i.v & cmd_i.ready;
  assign clint_wr    = accept & is_clint & cmd_i.wr;

  always_comb
  begin
    case (cmd_i.addr.fields.offset)
      uncore_pkg::MSIP_OFF:     clint_rd = {{(uncore_pkg::DATA_W-1){1'b0}}, msip_q};
      uncore_pkg::MTIMECMP_OFF: clint_rd = mtimecmp_q;
      uncore_pkg::MTIME_OFF:    clint_rd = mtime_q;
      default:                  clint_rd = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      timer_irq_q <= 1'b0;
    end
    else
    begin
      mtime_q     <= mtime_q + 1'b1;
      timer_irq_q <= mtime_q >= mtimecmp_q;
      if (clint_wr)
      begin
        case (cmd_i.addr.fields.offset)
          uncore_pkg::MSIP_OFF:     msip_q <= cmd_i.data[0];
          uncore_pkg::MTIMECMP_OFF: mtimecmp_q <= cmd_i.data;
          uncore_pkg::MTIME_OFF:    mtime_q <= cmd_i.data;
          default:                  ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      clint_v_q <= 1'b0;
      loop_v_q  <= 1'b0;
    end
    else
    begin
      if (clint_resp_o.v && clint_resp_o.ready)
        clint_v_q <= 1'b0;
      if (loop_resp_o.v && loop_resp_o.ready)
        loop_v_q <= 1'b0;
      if (accept && is_clint)
        clint_v_q <= 1'b1;
      if (accept && !is_clint)
        loop_v_q <= 1'b1;
    end
  end

  // Only one response is ever held, so both share the payload
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_wr_q    <= cmd_i.wr;
      resp_id_q    <= cmd_i.lce_id;
      resp_addr_q  <= cmd_i.addr;
      clint_data_q <= cmd_i.wr ? '0 : clint_rd;
    end
  end

  assign clint_resp_o.v      = clint_v_q;
  assign clint_resp_o.wr     = resp_wr_q;
  assign clint_resp_o.lce_id = resp_id_q;
  assign clint_resp_o.addr   = resp_addr_q;
  assign clint_resp_o.data   = clint_data_q;

  assign loop_resp_o.v      = loop_v_q;
  assign loop_resp_o.wr     = resp_wr_q;
  assign loop_resp_o.lce_id = resp_id_q;
  assign loop_resp_o.addr   = resp_addr_q;
  assign loop_resp_o.data   = '0;

  assign timer_irq_o    = timer_irq_q;
  assign software_irq_o = msip_q;

endmodule

//--- src/resp_router.sv
module resp_router
  (mem_msg_if.dst  loop_i
  , mem_msg_if.dst mem_i
  , mem_msg_if.dst io_i
  , mem_msg_if.dst clint_i
  , mem_msg_if.src resp_o [uncore_pkg::NUM_REQ]
  );

  // Source order, highest priority on top: loopback, memory, I/O, CLINT
  logic [3:0]                               req;
  logic [3:0]                               grant;
  logic [3:0]                               wr_a;
  logic [3:0][uncore_pkg::LCE_ID_W-1:0]     id_a;
  logic [3:0][uncore_pkg::PADDR_W-1:0]      addr_a;
  logic [3:0][uncore_pkg::DATA_W-1:0]       data_a;
  logic [uncore_pkg::NUM_REQ-1:0]           ready_a;

  logic                             sel_wr;
  logic [uncore_pkg::LCE_ID_W-1:0]  sel_id;
  logic [uncore_pkg::PADDR_W-1:0]   sel_addr;
  logic [uncore_pkg::DATA_W-1:0]    sel_data;

  assign req    = {loop_i.v, mem_i.v, io_i.v, clint_i.v};
  assign wr_a   = {loop_i.wr, mem_i.wr, io_i.wr, clint_i.wr};
  assign id_a   = {loop_i.lce_id, mem_i.lce_id, io_i.lce_id, clint_i.lce_id};
  assign addr_a = {loop_i.addr.raw, mem_i.addr.raw, io_i.addr.raw, clint_i.addr.raw};
  assign data_a = {loop_i.data, mem_i.data, io_i.data, clint_i.data};

  // Taken only while every response FIFO has room
  always_comb
  begin
    grant = '0;
    for (int i = 0; i < 4; i++)
    begin
      if (req[i] && (&ready_a))
      begin
        grant    = '0;
        grant[i] = 1'b1;
      end
    end
  end

  assign {loop_i.ready, mem_i.ready, io_i.ready, clint_i.ready} = grant;

  always_comb
  begin
    sel_wr   = 1'b0;
    sel_id   = '0;
    sel_addr = '0;
    sel_data = '0;
    for (int i = 0; i < 4; i++)
    begin
      sel_wr   = sel_wr | (wr_a[i] & grant[i]);
      sel_id   = sel_id | (id_a[i] & {uncore_pkg::LCE_ID_W{grant[i]}});
      sel_addr = sel_addr | (addr_a[i] & {uncore_pkg::PADDR_W{grant[i]}});
      sel_data = sel_data | (data_a[i] & {uncore_pkg::DATA_W{grant[i]}});
    end
  end

  for (genvar i = 0; i < uncore_pkg::NUM_REQ; i++)
  begin : g_out
    assign ready_a[i]       = resp_o[i].ready;
    assign resp_o[i].v      = (|grant) & (int'(sel_id) == i);
    assign resp_o[i].wr     = sel_wr;
    assign resp_o[i].lce_id = sel_id;
    assign resp_o[i].addr   = sel_addr;
    assign resp_o[i].data   = sel_data;
  end

endmodule

//--- src/uncore_top.sv
module uncore_top
  (input  logic                                                   clk_i
  , input  logic                                                  rst_n_i

  , input  logic [uncore_pkg::NUM_REQ-1:0]                        proc_cmd_v_i
  , input  logic [uncore_pkg::NUM_REQ-1:0]                        proc_cmd_wr_i
  , input  logic [uncore_pkg::NUM_REQ-1:0][uncore_pkg::PADDR_W-1:0] proc_cmd_addr_i
  , input  logic [uncore_pkg::NUM_REQ-1:0][uncore_pkg::DATA_W-1:0]  proc_cmd_data_i
  , output logic [uncore_pkg::NUM_REQ-1:0]                        proc_cmd_ready_o

  , output logic [uncore_pkg::NUM_REQ-1:0]                        proc_resp_v_o
  , output logic [uncore_pkg::NUM_REQ-1:0][uncore_pkg::DATA_W-1:0]  proc_resp_data_o
  , input  logic [uncore_pkg::NUM_REQ-1:0]                        proc_resp_ready_i

  , output logic                                                  io_cmd_v_o
  , output logic                                                  io_cmd_wr_o
  , output logic [uncore_pkg::LCE_ID_W-1:0]                       io_cmd_lce_id_o
  , output logic [uncore_pkg::PADDR_W-1:0]                        io_cmd_addr_o
  , output logic [uncore_pkg::DATA_W-1:0]                         io_cmd_data_o
  , input  logic                                                  io_cmd_ready_i
  , input  logic                                                  io_resp_v_i
  , input  logic [uncore_pkg::LCE_ID_W-1:0]                       io_resp_lce_id_i
  , input  logic [uncore_pkg::DATA_W-1:0]                         io_resp_data_i
  , output logic                                                  io_resp_yumi_o

  , output logic                                                  mem_cmd_v_o
  , output logic                                                  mem_cmd_wr_o
  , output logic [uncore_pkg::LCE_ID_W-1:0]                       mem_cmd_lce_id_o
  , output logic [uncore_pkg::PADDR_W-1:0]                        mem_cmd_addr_o
  , output logic [uncore_pkg::DATA_W-1:0]                         mem_cmd_data_o
  , input  logic                                                  mem_cmd_ready_i
  , input  logic                                                  mem_resp_v_i
  , input  logic [uncore_pkg::LCE_ID_W-1:0]                       mem_resp_lce_id_i
  , input  logic [uncore_pkg::DATA_W-1:0]                         mem_resp_data_i
  , output logic                                                  mem_resp_yumi_o

  , output logic                                                  timer_irq_o
  , output logic                                                  software_irq_o
  );

  mem_msg_if cmd_in [uncore_pkg::NUM_REQ] ();
  mem_msg_if cmd_q [uncore_pkg::NUM_REQ] ();
  mem_msg_if resp_in [uncore_pkg::NUM_REQ] ();
  mem_msg_if resp_q [uncore_pkg::NUM_REQ] ();
  mem_msg_if io_cmd ();
  mem_msg_if mem_cmd ();
  mem_msg_if local_cmd ();
  mem_msg_if io_resp ();
  mem_msg_if mem_resp ();
  mem_msg_if clint_resp ();
  mem_msg_if loop_resp ();

  for (genvar i = 0; i < uncore_pkg::NUM_REQ; i++)
  begin : g_port
    // Port index becomes the requester id
    assign cmd_in[i].v        = proc_cmd_v_i[i];
    assign cmd_in[i].wr       = proc_cmd_wr_i[i];
    assign cmd_in[i].lce_id   = uncore_pkg::LCE_ID_W'(i);
    assign cmd_in[i].addr.raw = proc_cmd_addr_i[i];
    assign cmd_in[i].data     = proc_cmd_data_i[i];
    assign proc_cmd_ready_o[i] = cmd_in[i].ready;

    two_entry_fifo i_cmd_fifo (.clk_i, .rst_n_i, .in_i(cmd_in[i]), .out_o(cmd_q[i]));
    two_entry_fifo i_resp_fifo (.clk_i, .rst_n_i, .in_i(resp_in[i]), .out_o(resp_q[i]));

    assign proc_resp_v_o[i]    = resp_q[i].v;
    assign proc_resp_data_o[i] = resp_q[i].data;
    assign resp_q[i].ready     = proc_resp_ready_i[i];
  end

  cmd_router i_cmd_router
    (.cmd_i(cmd_q)
    , .io_o(io_cmd)
    , .mem_o(mem_cmd)
    , .local_o(local_cmd)
    );

  assign io_cmd_v_o      = io_cmd.v;
  assign io_cmd_wr_o     = io_cmd.wr;
  assign io_cmd_lce_id_o = io_cmd.lce_id;
  assign io_cmd_addr_o   = io_cmd.addr.raw;
  assign io_cmd_data_o   = io_cmd.data;
  assign io_cmd.ready    = io_cmd_ready_i;

  assign mem_cmd_v_o      = mem_cmd.v;
  assign mem_cmd_wr_o     = mem_cmd.wr;
  assign mem_cmd_lce_id_o = mem_cmd.lce_id;
  assign mem_cmd_addr_o   = mem_cmd.addr.raw;
  assign mem_cmd_data_o   = mem_cmd.data;
  assign mem_cmd.ready    = mem_cmd_ready_i;

  local_devices i_local_devices
    (.clk_i
    , .rst_n_i
    , .cmd_i(local_cmd)
    , .clint_resp_o(clint_resp)
    , .loop_resp_o(loop_resp)
    , .timer_irq_o
    , .software_irq_o
    );

  // External responses carry only id and data
  assign io_resp.v        = io_resp_v_i;
  assign io_resp.wr       = 1'b0;
  assign io_resp.lce_id   = io_resp_lce_id_i;
  assign io_resp.addr.raw = '0;
  assign io_resp.data     = io_resp_data_i;
  assign io_resp_yumi_o   = io_resp.ready;

  assign mem_resp.v        = mem_resp_v_i;
  assign mem_resp.wr       = 1'b0;
  assign mem_resp.lce_id   = mem_resp_lce_id_i;
  assign mem_resp.addr.raw = '0;
  assign mem_resp.data     = mem_resp_data_i;
  assign mem_resp_yumi_o   = mem_resp.ready;

  resp_router i_resp_router
    (.loop_i(loop_resp)
    , .mem_i(mem_resp)
    , .io_i(io_resp)
    , .clint_i(clint_resp)
    , .resp_o(resp_in)
    );

endmodule

//--- tests/uncore_chk.sv
module uncore_chk
  (input logic                                                     clk_i
  , input logic                                                    rst_n_i
  , input logic [uncore_pkg::NUM_REQ-1:0]                          proc_cmd_ready_o
  , input logic [uncore_pkg::NUM_REQ-1:0]                          proc_resp_v_o
  , input logic [uncore_pkg::NUM_REQ-1:0][uncore_pkg::DATA_W-1:0]  proc_resp_data_o
  , input logic [uncore_pkg::NUM_REQ-1:0]                          proc_resp_ready_i
  , input logic                                                    io_cmd_v_o
  , input logic                                                    io_cmd_ready_i
  , input logic [uncore_pkg::PADDR_W-1:0]                          io_cmd_addr_o
  , input logic [uncore_pkg::DATA_W-1:0]                           io_cmd_data_o
  , input logic                                                    mem_cmd_v_o
  , input logic                                                    mem_cmd_ready_i
  , input logic [uncore_pkg::PADDR_W-1:0]                          mem_cmd_addr_o
  , input logic [uncore_pkg::DATA_W-1:0]                           mem_cmd_data_o
  , input logic                                                    io_resp_yumi_o
  , input logic                                                    mem_resp_yumi_o
  , input logic                                                    timer_irq_o
  , input logic                                                    software_irq_o
  );
  timeunit 1ns;
  timeprecision 1ps;

  one_dest_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(io_cmd_v_o && mem_cmd_v_o))
    else $error("io and mem commands valid together");

  io_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    io_cmd_v_o && !io_cmd_ready_i |=> $stable({io_cmd_addr_o, io_cmd_data_o}))
    else $error("io command changed while stalled");

  mem_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_cmd_v_o && !mem_cmd_ready_i |=> $stable({mem_cmd_addr_o, mem_cmd_data_o}))
    else $error("mem command changed while stalled");

  for (genvar i = 0; i < uncore_pkg::NUM_REQ; i++)
  begin : g_resp
    resp_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      proc_resp_v_o[i] && !proc_resp_ready_i[i]
        |=> proc_resp_v_o[i] && $stable(proc_resp_data_o[i]))
      else $error("response dropped or changed while stalled");
  end

  reset_a: assert property (@(posedge clk_i)
    !rst_n_i |=> (proc_resp_v_o == '0) && (proc_cmd_ready_o == '1) && !io_cmd_v_o
      && !mem_cmd_v_o && !io_resp_yumi_o && !mem_resp_yumi_o && !timer_irq_o
      && !software_irq_o)
    else $error("outputs not idle after reset");

endmodule

bind uncore_top uncore_chk i_chk
  (.clk_i
  , .rst_n_i
  , .proc_cmd_ready_o
  , .proc_resp_v_o
  , .proc_resp_data_o
  , .proc_resp_ready_i
  , .io_cmd_v_o
  , .io_cmd_ready_i
  , .io_cmd_addr_o
  , .io_cmd_data_o
  , .mem_cmd_v_o
  , .mem_cmd_ready_i
  , .mem_cmd_addr_o
  , .mem_cmd_data_o
  , .io_resp_yumi_o
  , .mem_resp_yumi_o
  , .timer_irq_o
  , .software_irq_o
  );

//--- tests/tb_uncore.sv
module tb_uncore;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NP = uncore_pkg::NUM_REQ;
  localparam logic [63:0] IO_PAT = 64'h5a5a_0000_0000_5a5a;
  localparam int D_IO  = 0;
  localparam int D_MEM = 1;
  localparam int D_LOC = 2;
  // Check kinds: plain data, data then irq lines, increasing mtime
  localparam int K_DATA  = 0;
  localparam int K_IRQ   = 1;
  localparam int K_MTIME = 2;

  typedef struct {
    int          p;
    logic        wr;
    logic [39:0] addr;
    logic [63:0] data;
    int          dest;
    logic [63:0] exp;
    int          kind;
    logic [1:0]  irq;
  } entry_t;

  logic                  clk_i;
  logic                  rst_n_i;
  logic [NP-1:0]         proc_cmd_v_i;
  logic [NP-1:0]         proc_cmd_wr_i;
  logic [NP-1:0][39:0]   proc_cmd_addr_i;
  logic [NP-1:0][63:0]   proc_cmd_data_i;
  logic [NP-1:0]         proc_cmd_ready_o;
  logic [NP-1:0]         proc_resp_v_o;
  logic [NP-1:0][63:0]   proc_resp_data_o;
  logic [NP-1:0]         proc_resp_ready_i;
  logic                  io_cmd_v_o;
  logic                  io_cmd_wr_o;
  logic [1:0]            io_cmd_lce_id_o;
  logic [39:0]           io_cmd_addr_o;
  logic [63:0]           io_cmd_data_o;
  logic                  io_cmd_ready_i;
  logic                  io_resp_v_i;
  logic [1:0]            io_resp_lce_id_i;
  logic [63:0]           io_resp_data_i;
  logic                  io_resp_yumi_o;
  logic                  mem_cmd_v_o;
  logic                  mem_cmd_wr_o;
  logic [1:0]            mem_cmd_lce_id_o;
  logic [39:0]           mem_cmd_addr_o;
  logic [63:0]           mem_cmd_data_o;
  logic                  mem_cmd_ready_i;
  logic                  mem_resp_v_i;
  logic [1:0]            mem_resp_lce_id_i;
  logic [63:0]           mem_resp_data_i;
  logic                  mem_resp_yumi_o;
  logic                  timer_irq_o;
  logic                  software_irq_o;

  entry_t      tbl[$];
  logic [63:0] mem_model [logic [39:0]];
  logic [1:0]  io_id_q[$];
  logic [63:0] io_data_q[$];
  longint      io_due_q[$];
  logic [1:0]  mem_id_q[$];
  logic [63:0] mem_data_q[$];
  longint      mem_due_q[$];
  logic [63:0] got_q[NP][$];
  int          got_dest_q[NP][$];
  logic [63:0] exp_q[NP][$];
  int          last_dest[NP];
  logic [64:0] io_cmd_seen[NP];
  longint      cyc;
  int          seed;
  int          errors;
  int          checks;
  bit          rnd_ready;

  uncore_top i_dut (.*);

  always #4 clk_i = ~clk_i;

  // Handshakes are sampled here, before the edge updates any state
  always @(posedge clk_i)
  begin
    if (rst_n_i)
    begin
      cyc++;
      if (io_resp_v_i && io_resp_yumi_o)
      begin
        void'(io_id_q.pop_front());
        void'(io_data_q.pop_front());
        void'(io_due_q.pop_front());
      end
      if (mem_resp_v_i && mem_resp_yumi_o)
      begin
        void'(mem_id_q.pop_front());
        void'(mem_data_q.pop_front());
        void'(mem_due_q.pop_front());
      end
      if (io_cmd_v_o && io_cmd_ready_i)
      begin
        io_id_q.push_back(io_cmd_lce_id_o);
        io_data_q.push_back({24'h0, io_cmd_addr_o} ^ IO_PAT);
        io_due_q.push_back(cyc + longint'(1 + int'($unsigned($random(seed)) % 32'd3)));
        last_dest[io_cmd_lce_id_o] = D_IO;
        io_cmd_seen[io_cmd_lce_id_o] = {io_cmd_wr_o, io_cmd_data_o};
      end
      if (mem_cmd_v_o && mem_cmd_ready_i)
      begin
        mem_id_q.push_back(mem_cmd_lce_id_o);
        if (mem_cmd_wr_o)
        begin
          mem_model[mem_cmd_addr_o] = mem_cmd_data_o;
          mem_data_q.push_back(64'h0);
        end
        else
          mem_data_q.push_back(mem_model.exists(mem_cmd_addr_o) ?
                               mem_model[mem_cmd_addr_o] : 64'h0);
        mem_due_q.push_back(cyc + 1);
        last_dest[mem_cmd_lce_id_o] = D_MEM;
      end
      for (int p = 0; p < NP; p++)
      begin
        if (proc_resp_v_o[p] && proc_resp_ready_i[p])
        begin
          got_q[p].push_back(proc_resp_data_o[p]);
          got_dest_q[p].push_back(last_dest[p]);
        end
      end
    end
  end

  // I/O and memory models and ready lines
  always @(negedge clk_i)
  begin
    io_cmd_ready_i    = 1'($random(seed));
    mem_cmd_ready_i   = rnd_ready ? 1'($random(seed)) : 1'b1;
    proc_resp_ready_i = rnd_ready ? 3'($random(seed)) : 3'b111;
    io_resp_v_i       = 1'b0;
    mem_resp_v_i      = 1'b0;
    if (io_id_q.size() > 0)
    begin
      io_resp_v_i      = cyc >= io_due_q[0];
      io_resp_lce_id_i = io_id_q[0];
      io_resp_data_i   = io_data_q[0];
    end
    if (mem_id_q.size() > 0)
    begin
      mem_resp_v_i      = cyc >= mem_due_q[0];
      mem_resp_lce_id_i = mem_id_q[0];
      mem_resp_data_i   = mem_data_q[0];
    end
  end

  task automatic add_entry(int p, logic wr, logic [39:0] a, logic [63:0] d, int dest,
                           logic [63:0] exp, int kind, logic [1:0] irq);
    entry_t e;
    e = '{p, wr, a, d, dest, exp, kind, irq};
    tbl.push_back(e);
  endtask

  task automatic issue_cmd(int p, logic wr, logic [39:0] a, logic [63:0] d);
    @(negedge clk_i);
    proc_cmd_wr_i[p]   = wr;
    proc_cmd_addr_i[p] = a;
    proc_cmd_data_i[p] = d;
    proc_cmd_v_i[p]    = 1'b1;
    while (!proc_cmd_ready_o[p])
      @(negedge clk_i);
    @(negedge clk_i);
    proc_cmd_v_i[p] = 1'b0;
  endtask

  task automatic wait_resp(int p, output bit ok);
    int n;
    n = 0;
    while (got_q[p].size() == 0 && n < 200)
    begin
      @(negedge clk_i);
      n++;
    end
    ok = got_q[p].size() > 0;
  endtask

  task automatic burst_port(int p);
    logic [39:0] a;
    logic [63:0] d;
    logic        wr;
    for (int k = 0; k < 8; k++)
    begin
      d  = 64'h0;
      wr = 1'b0;
      if (p == 0)
      begin
        // Four memory writes, then read them back
        a  = 40'h00_8000_1000 + 40'(8 * (k % 4));
        wr = k < 4;
        d  = {32'hd0d0_0000, 32'(k % 4)};
        exp_q[p].push_back(wr ? 64'h0 : d);
      end
      else if (p == 1)
      begin
        a = 40'h00_0030_0000 + 40'(8 * k);
        exp_q[p].push_back({24'h0, a} ^ IO_PAT);
      end
      else
      begin
        a  = 40'h00_0020_0000 + 40'(8 * k);
        wr = 1'(k);
        exp_q[p].push_back(64'h0);
      end
      issue_cmd(p, wr, a, d);
    end
  endtask

  task automatic run_table();
    entry_t      e;
    bit          ok;
    int          dest;
    logic [63:0] data;
    logic [63:0] prev_mtime;
    prev_mtime = 64'h0;
    for (int i = 0; i < tbl.size(); i++)
    begin
      e = tbl[i];
      last_dest[e.p] = D_LOC;
      issue_cmd(e.p, e.wr, e.addr, e.data);
      wait_resp(e.p, ok);
      checks++;
      assert (ok) else
      begin
        errors++;
        $display("entry %0d: no response arrived on port %0d", i, e.p);
      end
      if (ok)
      begin
        dest = got_dest_q[e.p].pop_front();
        data = got_q[e.p].pop_front();
        assert (dest == e.dest) else
        begin
          errors++;
          $display("FAIL entry %0d destination: got %0h expected %0h", i, dest, e.dest);
        end
        if (e.dest == D_IO)
          assert (io_cmd_seen[e.p] == {e.wr, e.data}) else
          begin
            errors++;
            $display("FAIL entry %0d {io_cmd_wr_o,io_cmd_data_o}: got %0h expected %0h",
                     i, io_cmd_seen[e.p], {e.wr, e.data});
          end
        if (e.kind == K_MTIME)
        begin
          assert (data > prev_mtime) else
          begin
            errors++;
            $display("FAIL entry %0d mtime: got %0h previous %0h", i, data, prev_mtime);
          end
          prev_mtime = data;
        end
        else
          assert (data == e.exp) else
          begin
            errors++;
            $display("FAIL entry %0d proc_resp_data_o: got %0h expected %0h",
                     i, data, e.exp);
          end
        if (e.kind == K_IRQ)
        begin
          repeat (2) @(negedge clk_i);
          assert ({timer_irq_o, software_irq_o} == e.irq) else
          begin
            errors++;
            $display("FAIL entry %0d {timer_irq_o,software_irq_o}: got %0h expected %0h",
                     i, {timer_irq_o, software_irq_o}, e.irq);
          end
        end
      end
      repeat (4) @(negedge clk_i);
      for (int q = 0; q < NP; q++)
      begin
        assert (got_q[q].size() == 0) else
        begin
          errors++;
          $display("entry %0d: unexpected response on port %0d", i, q);
          got_q[q].delete();
          got_dest_q[q].delete();
        end
      end
    end
  endtask

  task automatic run_burst();
    int          n;
    logic [63:0] data;
    @(posedge clk_i);
    rnd_ready = 1'b1;
    fork
      burst_port(0);
      burst_port(1);
      burst_port(2);
    join
    n = 0;
    while (n < 2000 && (got_q[0].size() < exp_q[0].size() || got_q[1].size() < exp_q[1].size()
           || got_q[2].size() < exp_q[2].size()))
    begin
      @(negedge clk_i);
      n++;
    end
    repeat (10) @(negedge clk_i);
    for (int p = 0; p < NP; p++)
    begin
      checks++;
      assert (got_q[p].size() == exp_q[p].size()) else
      begin
        errors++;
        $display("burst port %0d: %0d responses for %0d commands",
                 p, got_q[p].size(), exp_q[p].size());
      end
      while (got_q[p].size() > 0 && exp_q[p].size() > 0)
      begin
        data = got_q[p].pop_front();
        assert (data == exp_q[p][0]) else
        begin
          errors++;
          $display("FAIL burst port %0d proc_resp_data_o: got %0h expected %0h",
                   p, data, exp_q[p][0]);
        end
        void'(exp_q[p].pop_front());
      end
    end
  endtask

  initial
  begin
    #1;
    repeat (tbl.size() * 200 + 2000) @(posedge clk_i);
    $display("watchdog expired before the tests finished");
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    proc_cmd_v_i = '0;
    proc_cmd_wr_i = '0;
    proc_cmd_addr_i = '0;
    proc_cmd_data_i = '0;
    proc_resp_ready_i = '1;
    io_cmd_ready_i = 1'b0;
    io_resp_v_i = 1'b0;
    io_resp_lce_id_i = '0;
    io_resp_data_i = '0;
    mem_cmd_ready_i = 1'b0;
    mem_resp_v_i = 1'b0;
    mem_resp_lce_id_i = '0;
    mem_resp_data_i = '0;
    seed = 32'hc3e43fb3;
    cyc = 0;
    errors = 0;
    checks = 0;
    rnd_ready = 1'b0;

    add_entry(0, 1'b0, 40'h00_8000_0100, 64'h0, D_MEM, 64'h0, K_DATA, 2'b00);
    add_entry(1, 1'b1, 40'h00_8000_0100, 64'h1122_3344_5566_7788, D_MEM, 64'h0, K_DATA, 2'b00);
    add_entry(2, 1'b0, 40'h00_8000_0100, 64'h0, D_MEM, 64'h1122_3344_5566_7788, K_DATA, 2'b00);
    add_entry(0, 1'b0, 40'h00_0000_0040, 64'h0, D_IO, 64'h0000_0000_0000_0040 ^ IO_PAT,
              K_DATA, 2'b00);
    add_entry(1, 1'b1, 40'h00_0030_0008, 64'h77, D_IO, 64'h0000_0000_0030_0008 ^ IO_PAT,
              K_DATA, 2'b00);
    add_entry(2, 1'b0, 40'h02_0000_1000, 64'h0, D_IO, 64'h0000_0002_0000_1000 ^ IO_PAT,
              K_DATA, 2'b00);
    add_entry(0, 1'b0, 40'h00_0040_0010, 64'h0, D_MEM, 64'h0, K_DATA, 2'b00);
    add_entry(1, 1'b0, 40'h00_0020_0000, 64'h0, D_LOC, 64'h0, K_DATA, 2'b00);
    add_entry(2, 1'b1, 40'h00_0050_0000, 64'h55, D_LOC, 64'h0, K_DATA, 2'b00);
    add_entry(0, 1'b1, 40'h00_0010_0000, 64'h1, D_LOC, 64'h0, K_IRQ, 2'b01);
    add_entry(0, 1'b0, 40'h00_0010_0000, 64'h0, D_LOC, 64'h1, K_DATA, 2'b00);
    add_entry(1, 1'b1, 40'h00_0010_0000, 64'h0, D_LOC, 64'h0, K_IRQ, 2'b00);
    add_entry(2, 1'b1, 40'h00_0010_4000, 64'h0, D_LOC, 64'h0, K_IRQ, 2'b10);
    add_entry(2, 1'b1, 40'h00_0010_4000, '1, D_LOC, 64'h0, K_IRQ, 2'b00);
    add_entry(0, 1'b0, 40'h00_0010_4000, 64'h0, D_LOC, '1, K_DATA, 2'b00);
    add_entry(1, 1'b0, 40'h00_0010_bff8, 64'h0, D_LOC, 64'h0, K_MTIME, 2'b00);
    add_entry(1, 1'b0, 40'h00_0010_bff8, 64'h0, D_LOC, 64'h0, K_MTIME, 2'b00);
    add_entry(0, 1'b0, 40'h00_0010_0100, 64'h0, D_LOC, 64'h0, K_DATA, 2'b00);

    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;
    run_table();
    run_burst();

    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- sources.f
src/uncore_pkg.sv
src/mem_msg_if.sv
src/two_entry_fifo.sv
src/cmd_router.sv
src/local_devices.sv
src/resp_router.sv
src/uncore_top.sv
tests/uncore_chk.sv
tests/tb_uncore.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module tb_uncore -o sim_uncore
out=$(./obj_dir/sim_uncore)
echo "$out"
echo "$out" | grep -q "TEST PASSED"
